//--- hw/i2c_pkg.sv
// Timing assumes a 100 MHz system clock; SCL_QUARTER_CYCLES sets a 100 kHz bus rate
package i2c_pkg;

    // ------------------------------------------------------------------
    // Timing and field widths
    // ------------------------------------------------------------------

    // System cycles per quarter of one SCL bit
    localparam logic [15:0] SCL_QUARTER_CYCLES = 16'd250;

    localparam int I2C_ADDR_W = 7;
    localparam int I2C_DATA_W = 8;

    // Eight data bits plus the ACK slot
    localparam int BITS_PER_FRAME = 9;
    localparam int FRAME_CNT_W    = $clog2(BITS_PER_FRAME);

    // ------------------------------------------------------------------
    // Bus constants
    // ------------------------------------------------------------------

    // Level the target drives in the ACK slot
    localparam logic SDA_ACK = 1'b0;
    // R/W bit value for a read
    localparam logic RW_READ = 1'b1;

    // ------------------------------------------------------------------
    // Enumerations
    // ------------------------------------------------------------------

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_WRITE,
        ST_WRITE_ACK,
        ST_READ,
        ST_MASTER_NACK,
        ST_STOP,
        ST_RESPOND
    } ctrl_state_t;

    // Quarter phases of one SCL bit
    typedef enum logic [1:0] {
        PH_LOW_A,
        PH_RISE,
        PH_HIGH,
        PH_LOW_B
    } phase_t;

endpackage

//--- hw/i2c_bit_if.sv
// Byte shifter control link; tx_byte is taken on load, sample_bit on shift_en
`timescale 1ns/1ns

interface i2c_bit_if;
    import i2c_pkg::*;

    // Driven by the FSM
    logic                  load;
    logic [I2C_DATA_W-1:0] tx_byte;
    logic                  shift_en;
    logic                  sample_bit;

    // Driven by the shifter
    logic                  tx_bit;
    logic [I2C_DATA_W-1:0] rx_byte;
    logic                  last_bit;

    modport fsm (
        output load,
        output tx_byte,
        output shift_en,
        output sample_bit,
        input  tx_bit,
        input  rx_byte,
        input  last_bit
    );

    modport shifter (
        input  load,
        input  tx_byte,
        input  shift_en,
        input  sample_bit,
        output tx_bit,
        output rx_byte,
        output last_bit
    );

endinterface

//--- hw/i2c_phase_timer.sv
// Needs QUARTER_CYCLES >= 2; a target holding SCL low stalls the timer in PH_RISE indefinitely
`timescale 1ns/1ns

module i2c_phase_timer #(
    parameter logic [15:0] QUARTER_CYCLES = i2c_pkg::SCL_QUARTER_CYCLES
) (
    input  logic            CLK_100MHz,
    input  logic            RST,
    input  logic            run,
    input  logic            scl_in,
    output i2c_pkg::phase_t phase,
    output logic            phase_tick
);
    import i2c_pkg::*;

    logic [15:0] count;
    logic        quarter_done;
    logic        may_advance;

    assign quarter_done = (count == QUARTER_CYCLES - 16'd1);

    // Rising quarter waits until the line is seen high (clock stretching)
    assign may_advance = (phase != PH_RISE) || scl_in;

    always_ff @(posedge CLK_100MHz or posedge RST) begin
        if (RST) begin
            count      <= '0;
            phase      <= PH_LOW_A;
            phase_tick <= 1'b0;
        end else begin
            phase_tick <= 1'b0;
            if (!run) begin
                count <= '0;
                phase <= PH_LOW_A;
            end else if (quarter_done) begin
                if (may_advance) begin
                    count      <= '0;
                    phase      <= phase_t'(phase + 2'd1);
                    phase_tick <= 1'b1;
                end
            end else begin
                count <= count + 16'd1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    // FSM only drops run right after a tick, so no tick may follow
    a_no_tick_when_idle: assert property (
        @(posedge CLK_100MHz) disable iff (RST)
        !run |-> !phase_tick
    );

endmodule

//--- hw/i2c_byte_shifter.sv
// MSB first; rx_byte holds the last eight sampled bits, tx_bit is undefined until the first load
`timescale 1ns/1ns

module i2c_byte_shifter (
    input logic        CLK_100MHz,
    input logic        RST,
    i2c_bit_if.shifter bits
);
    import i2c_pkg::*;

    logic [I2C_DATA_W-1:0]  shift_q;
    logic [FRAME_CNT_W-1:0] bit_cnt;

    // One register serves both directions
    always_ff @(posedge CLK_100MHz) begin
        if (bits.load) begin
            shift_q <= bits.tx_byte;
        end else if (bits.shift_en) begin
            shift_q <= {shift_q[I2C_DATA_W-2:0], bits.sample_bit};
        end
    end

    // Counts shifted bits, stops at the ACK slot
    always_ff @(posedge CLK_100MHz or posedge RST) begin
        if (RST) begin
            bit_cnt <= '0;
        end else if (bits.load) begin
            bit_cnt <= '0;
        end else if (bits.shift_en && (bit_cnt != FRAME_CNT_W'(BITS_PER_FRAME - 1))) begin
            bit_cnt <= bit_cnt + FRAME_CNT_W'(1);
        end
    end

    assign bits.tx_bit   = shift_q[I2C_DATA_W-1];
    assign bits.rx_byte  = shift_q;
    assign bits.last_bit = (bit_cnt == FRAME_CNT_W'(I2C_DATA_W - 1));

    // Load and shift come from different phases of the bit
    a_load_shift_exclusive: assert property (
        @(posedge CLK_100MHz) disable iff (RST)
        !(bits.load && bits.shift_en)
    );

endmodule

//--- hw/i2c_line_sync.sv
// Inputs are asynchronous; outputs reset to 1 (idle bus) and ignore pulses of one cycle
`timescale 1ns/1ns

module i2c_line_sync (
    input  logic CLK_100MHz,
    input  logic RST,
    input  logic sda_line,
    input  logic scl_line,
    output logic sda_in,
    output logic scl_in
);

    // Bit 1 is SCL, bit 0 is SDA
    logic [1:0] raw;
    logic [1:0] meta_q;
    logic [1:0] samp_q;
    logic [1:0] filt_q;

    assign raw = {scl_line, sda_line};

    always_ff @(posedge CLK_100MHz or posedge RST) begin
        if (RST) begin
            meta_q <= 2'b11;
            samp_q <= 2'b11;
            filt_q <= 2'b11;
        end else begin
            meta_q <= raw;
            samp_q <= meta_q;
            // Take a new level only when two samples agree
            for (int i = 0; i < 2; i++) begin
                if (meta_q[i] == samp_q[i]) begin
                    filt_q[i] <= samp_q[i];
                end
            end
        end
    end

    assign sda_in = filt_q[0];
    assign scl_in = filt_q[1];

endmodule

//--- hw/i2c_ctrl_fsm.sv
// One command = START, address, one data byte, STOP; a read always ends with a master NACK
`timescale 1ns/1ns

module i2c_ctrl_fsm (
    input  logic                           CLK_100MHz,
    input  logic                           RST,
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic [i2c_pkg::I2C_ADDR_W-1:0] cmd_addr,
    input  logic                           cmd_rw,
    input  logic [i2c_pkg::I2C_DATA_W-1:0] cmd_wdata,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic [i2c_pkg::I2C_DATA_W-1:0] rsp_rdata,
    output logic                           rsp_ack_err,
    i2c_bit_if.fsm                         bits,
    input  i2c_pkg::phase_t                phase,
    input  logic                           phase_tick,
    input  logic                           sda_in,
    output logic                           run,
    output logic                           sda_pull_low,
    output logic                           scl_pull_low
);
    import i2c_pkg::*;

    ctrl_state_t           state;
    logic                  rw_q;
    logic [I2C_DATA_W-1:0] wdata_q;
    logic [I2C_DATA_W-1:0] rdata_q;
    logic                  ack_err_q;
    logic                  sampled_q;
    logic                  last_q;
    logic                  accept;
    logic                  tick_low_a;
    logic                  tick_high;

    assign accept     = (state == ST_IDLE) && cmd_valid;
    assign tick_low_a = phase_tick && (phase == PH_LOW_A);
    assign tick_high  = phase_tick && (phase == PH_HIGH);

    assign cmd_ready   = (state == ST_IDLE);
    assign rsp_valid   = (state == ST_RESPOND);
    assign rsp_rdata   = rdata_q;
    assign rsp_ack_err = ack_err_q;
    assign run         = (state != ST_IDLE) && (state != ST_RESPOND);

    // ------------------------------------------------------------------
    // Shifter control
    // ------------------------------------------------------------------

    // Address byte loads on accept, data byte during the address ACK slot
    assign bits.load    = accept || (tick_high && (state == ST_ADDR_ACK));
    assign bits.tx_byte = (state == ST_IDLE) ? {cmd_addr, cmd_rw} : wdata_q;
    assign bits.shift_en = tick_high &&
                           (state inside {ST_ADDR, ST_WRITE, ST_READ});
    assign bits.sample_bit = sda_in;

    always_ff @(posedge CLK_100MHz) begin
        if (accept) begin
            rw_q    <= cmd_rw;
            wdata_q <= cmd_wdata;
        end
    end

    // ------------------------------------------------------------------
    // Transaction sequencing
    // ------------------------------------------------------------------

    always_ff @(posedge CLK_100MHz or posedge RST) begin
        if (RST) begin
            state        <= ST_IDLE;
            rdata_q      <= '0;
            ack_err_q    <= 1'b0;
            sampled_q    <= 1'b1;
            last_q       <= 1'b0;
            sda_pull_low <= 1'b0;
            scl_pull_low <= 1'b0;
        end else begin
            // SCL released for the high half; left released after STOP
            if (phase_tick && (phase == PH_RISE)) begin
                scl_pull_low <= 1'b0;
            end
            if (phase_tick && (phase == PH_LOW_B)) begin
                scl_pull_low <= (state != ST_STOP);
            end
            if (tick_high) begin
                sampled_q <= sda_in;
                last_q    <= bits.last_bit;
            end

            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        state     <= ST_START;
                        rdata_q   <= '0;
                        ack_err_q <= 1'b0;
                    end
                end
                ST_START: begin
                    // SDA falls while SCL is high
                    if (tick_high) begin
                        sda_pull_low <= 1'b1;
                    end
                    if (tick_low_a) begin
                        state        <= ST_ADDR;
                        sda_pull_low <= !bits.tx_bit;
                    end
                end
                ST_ADDR, ST_WRITE: begin
                    if (tick_low_a) begin
                        if (last_q) begin
                            state        <= (state == ST_ADDR) ? ST_ADDR_ACK : ST_WRITE_ACK;
                            sda_pull_low <= 1'b0;
                        end else begin
                            sda_pull_low <= !bits.tx_bit;
                        end
                    end
                end
                ST_ADDR_ACK: begin
                    if (tick_low_a) begin
                        if (sampled_q != SDA_ACK) begin
                            state        <= ST_STOP;
                            ack_err_q    <= 1'b1;
                            sda_pull_low <= 1'b1;
                        end else if (rw_q == RW_READ) begin
                            state <= ST_READ;
                        end else begin
                            state        <= ST_WRITE;
                            sda_pull_low <= !bits.tx_bit;
                        end
                    end
                end
                ST_WRITE_ACK: begin
                    if (tick_low_a) begin
                        state        <= ST_STOP;
                        ack_err_q    <= (sampled_q != SDA_ACK);
                        sda_pull_low <= 1'b1;
                    end
                end
                ST_READ: begin
                    if (tick_low_a && last_q) begin
                        state   <= ST_MASTER_NACK;
                        rdata_q <= bits.rx_byte;
                    end
                end
                ST_MASTER_NACK: begin
                    // SDA stays released through the slot
                    if (tick_low_a) begin
                        state        <= ST_STOP;
                        sda_pull_low <= 1'b1;
                    end
                end
                ST_STOP: begin
                    if (tick_high) begin
                        sda_pull_low <= 1'b0;
                    end
                    if (tick_low_a) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    a_sda_stable_high: assert property (
        @(posedge CLK_100MHz) disable iff (RST)
        ((phase == PH_HIGH) && $changed(sda_pull_low)) |-> (state inside {ST_START, ST_STOP})
    );

    a_rsp_hold: assert property (
        @(posedge CLK_100MHz) disable iff (RST)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_ack_err))
    );

endmodule

//--- hw/i2c_master_top.sv
// Open-drain pull-low outputs only; the wired-AND bus and pull-ups are formed outside this block
`timescale 1ns/1ns

module i2c_master_top (
    input  logic                           CLK_100MHz,
    input  logic                           RST,
    // Command channel
    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic [i2c_pkg::I2C_ADDR_W-1:0] cmd_addr,
    input  logic                           cmd_rw,
    input  logic [i2c_pkg::I2C_DATA_W-1:0] cmd_wdata,
    // Response channel
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic [i2c_pkg::I2C_DATA_W-1:0] rsp_rdata,
    output logic                           rsp_ack_err,
    // Bus
    output logic                           sda_pull_low,
    output logic                           scl_pull_low,
    input  logic                           sda_line,
    input  logic                           scl_line
);
    import i2c_pkg::*;

    logic   sda_in;
    logic   scl_in;
    logic   run;
    phase_t phase;
    logic   phase_tick;

    i2c_bit_if bit_bus ();

    i2c_line_sync i_i2c_line_sync (
        .CLK_100MHz (CLK_100MHz),
        .RST        (RST),
        .sda_line   (sda_line),
        .scl_line   (scl_line),
        .sda_in     (sda_in),
        .scl_in     (scl_in)
    );

    i2c_phase_timer #(
        .QUARTER_CYCLES (SCL_QUARTER_CYCLES)
    ) i_i2c_phase_timer (
        .CLK_100MHz (CLK_100MHz),
        .RST        (RST),
        .run        (run),
        .scl_in     (scl_in),
        .phase      (phase),
        .phase_tick (phase_tick)
    );

    i2c_byte_shifter i_i2c_byte_shifter (
        .CLK_100MHz (CLK_100MHz),
        .RST        (RST),
        .bits       (bit_bus.shifter)
    );

    i2c_ctrl_fsm i_i2c_ctrl_fsm (
        .CLK_100MHz   (CLK_100MHz),
        .RST          (RST),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_addr     (cmd_addr),
        .cmd_rw       (cmd_rw),
        .cmd_wdata    (cmd_wdata),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_rdata    (rsp_rdata),
        .rsp_ack_err  (rsp_ack_err),
        .bits         (bit_bus.fsm),
        .phase        (phase),
        .phase_tick   (phase_tick),
        .sda_in       (sda_in),
        .run          (run),
        .sda_pull_low (sda_pull_low),
        .scl_pull_low (scl_pull_low)
    );

endmodule

//--- verification/i2c_target_model.sv
// One fixed address and one stored byte; write data 8'hFF gets a NACK; SCL stretched after addr ACK
`timescale 1ns/1ns

module i2c_target_model #(
    parameter logic [6:0] TARGET_ADDR = 7'h3A,
    parameter logic [7:0] RESET_BYTE  = 8'h5C
) (
    input  logic CLK_100MHz,
    input  logic RST,
    input  logic sda_line,
    input  logic scl_line,
    input  int   stretch_cycles,
    output logic sda_pull_low,
    output logic scl_pull_low
);

    typedef enum {T_IDLE, T_ADDR, T_ADDR_ACK, T_WRITE, T_WRITE_ACK, T_READ, T_WAIT} tgt_state_t;

    tgt_state_t state;
    logic [7:0] stored;
    logic [7:0] shreg;
    logic       rw;
    int         bit_cnt;
    int         stretch_left;
    logic       sda_q;
    logic       scl_q;
    logic       start_seen;
    logic       stop_seen;
    logic       scl_rise;
    logic       scl_fall;

    // Bus events from the previous and the current sample
    assign start_seen = scl_q && scl_line && sda_q && !sda_line;
    assign stop_seen  = scl_q && scl_line && !sda_q && sda_line;
    assign scl_rise   = !scl_q && scl_line;
    assign scl_fall   = scl_q && !scl_line;

    always_ff @(posedge CLK_100MHz or posedge RST) begin
        if (RST) begin
            state        <= T_IDLE;
            stored       <= RESET_BYTE;
            shreg        <= '0;
            rw           <= 1'b0;
            bit_cnt      <= 0;
            stretch_left <= 0;
            sda_q        <= 1'b1;
            scl_q        <= 1'b1;
            sda_pull_low <= 1'b0;
            scl_pull_low <= 1'b0;
        end else begin
            sda_q <= sda_line;
            scl_q <= scl_line;
            if (stretch_left > 0) begin
                stretch_left <= stretch_left - 1;
            end else begin
                scl_pull_low <= 1'b0;
            end

            if (stop_seen) begin
                state        <= T_IDLE;
                sda_pull_low <= 1'b0;
            end else if (start_seen) begin
                state        <= T_ADDR;
                bit_cnt      <= 0;
                sda_pull_low <= 1'b0;
            end else begin
                case (state)
                    T_ADDR, T_WRITE: begin
                        if (scl_rise) begin
                            shreg   <= {shreg[6:0], sda_line};
                            bit_cnt <= bit_cnt + 1;
                        end else if (scl_fall && (bit_cnt == 8)) begin
                            if (state == T_ADDR && shreg[7:1] == TARGET_ADDR) begin
                                sda_pull_low <= 1'b1;
                                rw           <= shreg[0];
                                state        <= T_ADDR_ACK;
                            end else if (state == T_WRITE && shreg != 8'hFF) begin
                                stored       <= shreg;
                                sda_pull_low <= 1'b1;
                                state        <= T_WRITE_ACK;
                            end else begin
                                state <= T_WAIT;
                            end
                        end
                    end
                    T_ADDR_ACK: begin
                        // End of the ACK slot, hold SCL low while the byte is prepared
                        if (scl_fall) begin
                            if (stretch_cycles > 0) begin
                                scl_pull_low <= 1'b1;
                                stretch_left <= stretch_cycles;
                            end
                            if (rw) begin
                                sda_pull_low <= !stored[7];
                                shreg        <= {stored[6:0], 1'b0};
                                bit_cnt      <= 1;
                                state        <= T_READ;
                            end else begin
                                sda_pull_low <= 1'b0;
                                bit_cnt      <= 0;
                                state        <= T_WRITE;
                            end
                        end
                    end
                    T_READ: begin
                        if (scl_fall && (bit_cnt == 8)) begin
                            sda_pull_low <= 1'b0;
                            state        <= T_WAIT;
                        end else if (scl_fall) begin
                            sda_pull_low <= !shreg[7];
                            shreg        <= {shreg[6:0], 1'b0};
                            bit_cnt      <= bit_cnt + 1;
                        end
                    end
                    T_WRITE_ACK: begin
                        if (scl_fall) begin
                            sda_pull_low <= 1'b0;
                            state        <= T_WAIT;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- verification/tb_i2c_master.sv
// Runs against the behavioural target at 7'h3A (reset byte 8'h5C); each wait gives up after 200000 cycles
`timescale 1ns/1ns

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int TIMEOUT_CYCLES = 200000;

    typedef struct {
        string                 name;
        logic                  rw;
        logic [I2C_ADDR_W-1:0] addr;
        logic [I2C_DATA_W-1:0] wdata;
        logic [I2C_DATA_W-1:0] exp_rdata;
        logic                  exp_ack_err;
        int                    stretch;
        int                    ready_delay;
    } test_entry_t;

    logic                  CLK_100MHz;
    logic                  RST;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic [I2C_ADDR_W-1:0] cmd_addr;
    logic                  cmd_rw;
    logic [I2C_DATA_W-1:0] cmd_wdata;
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [I2C_DATA_W-1:0] rsp_rdata;
    logic                  rsp_ack_err;
    logic                  sda_pull_low;
    logic                  scl_pull_low;
    logic                  tgt_sda_pull_low;
    logic                  tgt_scl_pull_low;
    logic                  sda_line;
    logic                  scl_line;
    int                    stretch_cycles;

    test_entry_t tests[$];
    int          error_count;
    int          pass_count;
    int          fail_count;
    bit          timed_out;

    // Wired-AND bus with pull-ups
    assign sda_line = !(sda_pull_low || tgt_sda_pull_low);
    assign scl_line = !(scl_pull_low || tgt_scl_pull_low);

    always #5 CLK_100MHz = ~CLK_100MHz;

    i2c_master_top i_i2c_master_top (
        .CLK_100MHz   (CLK_100MHz),
        .RST          (RST),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_addr     (cmd_addr),
        .cmd_rw       (cmd_rw),
        .cmd_wdata    (cmd_wdata),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_rdata    (rsp_rdata),
        .rsp_ack_err  (rsp_ack_err),
        .sda_pull_low (sda_pull_low),
        .scl_pull_low (scl_pull_low),
        .sda_line     (sda_line),
        .scl_line     (scl_line)
    );

    i2c_target_model i_i2c_target_model (
        .CLK_100MHz     (CLK_100MHz),
        .RST            (RST),
        .sda_line       (sda_line),
        .scl_line       (scl_line),
        .stretch_cycles (stretch_cycles),
        .sda_pull_low   (tgt_sda_pull_low),
        .scl_pull_low   (tgt_scl_pull_low)
    );

    // ------------------------------------------------------------------
    // Table, compares and waits
    // ------------------------------------------------------------------

    task automatic add_test(input string name, input logic rw, input logic [I2C_ADDR_W-1:0] addr,
                            input logic [I2C_DATA_W-1:0] wdata,
                            input logic [I2C_DATA_W-1:0] exp_rdata, input logic exp_ack_err,
                            input int stretch, input int ready_delay);
        test_entry_t e;
        e = '{name, rw, addr, wdata, exp_rdata, exp_ack_err, stretch, ready_delay};
        tests.push_back(e);
    endtask

    task automatic check_data(input string name, input logic [I2C_DATA_W-1:0] expected,
                              input logic [I2C_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected 8'h%h, actual 8'h%h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_for_cmd_ready(output bit ok);
        int cycles;
        cycles = 0;
        while (!cmd_ready && cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK_100MHz);
            #1;
            cycles++;
        end
        ok = cmd_ready;
    endtask

    task automatic wait_for_rsp_valid(output bit ok);
        int cycles;
        cycles = 0;
        while (!rsp_valid && cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK_100MHz);
            #1;
            cycles++;
        end
        ok = rsp_valid;
    endtask

    // One command, one response, then the idle bus check
    task automatic run_test(input test_entry_t t);
        int                    errors_before;
        bit                    ok;
        logic [I2C_DATA_W-1:0] held_rdata;
        logic [I2C_DATA_W-1:0] got_rdata;
        logic                  got_ack_err;
        errors_before  = error_count;
        stretch_cycles = t.stretch;
        cmd_addr       = t.addr;
        cmd_rw         = t.rw;
        cmd_wdata      = t.wdata;
        cmd_valid      = 1'b1;
        wait_for_cmd_ready(ok);
        if (!ok) begin
            $display("%s: timed out waiting for the controller to take the command", t.name);
            timed_out = 1'b1;
            fail_count++;
            return;
        end
        @(posedge CLK_100MHz);
        #1;
        cmd_valid = 1'b0;
        wait_for_rsp_valid(ok);
        if (!ok) begin
            $display("%s: timed out waiting for the response", t.name);
            timed_out = 1'b1;
            fail_count++;
            return;
        end
        held_rdata = rsp_rdata;
        for (int i = 0; i < t.ready_delay; i++) begin
            @(posedge CLK_100MHz);
            #1;
            check_flag({t.name, " rsp_valid held"}, 1'b1, rsp_valid);
            check_flag({t.name, " cmd_ready low"}, 1'b0, cmd_ready);
            check_data({t.name, " rdata held"}, held_rdata, rsp_rdata);
        end
        rsp_ready   = 1'b1;
        got_rdata   = rsp_rdata;
        got_ack_err = rsp_ack_err;
        @(posedge CLK_100MHz);
        #1;
        rsp_ready = 1'b0;
        check_flag({t.name, " ack_err"}, t.exp_ack_err, got_ack_err);
        if (t.rw == RW_READ && !t.exp_ack_err) begin
            check_data({t.name, " rdata"}, t.exp_rdata, got_rdata);
        end
        check_flag({t.name, " sda released"}, 1'b0, sda_pull_low);
        check_flag({t.name, " scl released"}, 1'b0, scl_pull_low);
        check_flag({t.name, " cmd_ready"}, 1'b1, cmd_ready);
        if (error_count == errors_before) begin
            pass_count++;
            $display("PASS %s", t.name);
        end else begin
            fail_count++;
            $display("FAIL %s", t.name);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        CLK_100MHz     = 1'b0;
        RST            = 1'b1;
        cmd_valid      = 1'b0;
        cmd_addr       = '0;
        cmd_rw         = 1'b0;
        cmd_wdata      = '0;
        rsp_ready      = 1'b0;
        stretch_cycles = 0;
        error_count    = 0;
        pass_count     = 0;
        fail_count     = 0;
        timed_out      = 1'b0;

        //       name                 rw    addr   wdata  rdata  err   stretch delay
        add_test("initial_read",      1'b1, 7'h3A, 8'h00, 8'h5C, 1'b0, 0,    0);
        add_test("write_a7",          1'b0, 7'h3A, 8'hA7, 8'h00, 1'b0, 0,    0);
        add_test("readback_a7",       1'b1, 7'h3A, 8'h00, 8'hA7, 1'b0, 0,    0);
        add_test("addr_nack",         1'b0, 7'h11, 8'h3C, 8'h00, 1'b1, 0,    0);
        add_test("data_nack_ff",      1'b0, 7'h3A, 8'hFF, 8'h00, 1'b1, 0,    0);
        add_test("read_after_nack",   1'b1, 7'h3A, 8'h00, 8'hA7, 1'b0, 0,    0);
        add_test("stretch_read",      1'b1, 7'h3A, 8'h00, 8'hA7, 1'b0, 3000, 0);
        add_test("backpressure_read", 1'b1, 7'h3A, 8'h00, 8'hA7, 1'b0, 0,    50);

        repeat (3) @(posedge CLK_100MHz);
        #1;
        RST = 1'b0;
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        check_flag("reset cmd_ready", 1'b1, cmd_ready);
        check_flag("reset sda_pull_low", 1'b0, sda_pull_low);
        check_flag("reset scl_pull_low", 1'b0, scl_pull_low);

        for (int i = 0; i < tests.size(); i++) begin
            if (!timed_out) begin
                run_test(tests[i]);
            end
        end

        $display("Summary: %0d tests passed, %0d failed, %0d check errors",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- all.f
hw/i2c_pkg.sv
hw/i2c_bit_if.sv
hw/i2c_phase_timer.sv
hw/i2c_byte_shifter.sv
hw/i2c_line_sync.sv
hw/i2c_ctrl_fsm.sv
hw/i2c_master_top.sv
verification/i2c_target_model.sv
verification/tb_i2c_master.sv

//--- Makefile
# Verilator lint and simulation of the I2C controller testbench

VERILATOR := verilator
FLAGS     := --sv --timing --assert
TOP       := tb_i2c_master
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The recipe fails unless the pass message shows up on a line of its own
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
